// ==== src/mipsPkg.sv ====
package mipsPkg;

    // plain widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [7:0]  intVec_t;

    // operation kinds seen by the memory stage
    typedef enum logic [3:0] {
        OP_NONE,
        OP_LW,
        OP_LH,
        OP_LHU,
        OP_LB,
        OP_LBU,
        OP_SW,
        OP_SH,
        OP_SB,
        OP_SYSCALL,
        OP_BREAK,
        OP_ERET
    } memOp_t;

    // record handed over by the execute stage
    typedef struct packed {
        memOp_t   op;
        // effective address for loads and stores
        word_t    aluOut;
        // store source before lane shifting
        word_t    writeData;
        regAddr_t writeReg;
        word_t    pcPlus4;
    } execData_t;

    // record handed to writeback
    typedef struct packed {
        memOp_t   op;
        word_t    aluOut;
        // extended load value, zero for anything else
        word_t    readData;
        regAddr_t writeReg;
        word_t    pcPlus4;
    } memData_t;

    // exception and interrupt status reported with each record
    typedef struct packed {
        logic    addrLoad;
        logic    addrStore;
        logic    sys;
        logic    bp;
        logic    eret;
        intVec_t pendingInt;
        word_t   excPc;
        word_t   badVaddr;
    } excInfo_t;

    // command presented to the data RAM
    typedef struct packed {
        word_t   addr;
        // all zero means a read
        byteEn_t wen;
        word_t   wdata;
    } ramReq_t;

    function automatic logic isLoad(memOp_t op);
        return op inside {OP_LW, OP_LH, OP_LHU, OP_LB, OP_LBU};
    endfunction

    function automatic logic isStore(memOp_t op);
        return op inside {OP_SW, OP_SH, OP_SB};
    endfunction

endpackage

// ==== src/storeAlign.sv ====
`timescale 1ns/1ps

module storeAlign (
    input  mipsPkg::memOp_t  op,
    input  logic [1:0]       addrLow,
    input  mipsPkg::word_t   srcData,
    output mipsPkg::byteEn_t wen,
    output mipsPkg::word_t   wdata
);

    // little-endian lanes, byte 0 sits in bits 7:0
    always_comb begin
        wen   = '0;
        wdata = srcData;
        case (op)
            mipsPkg::OP_SW: begin
                wen   = 4'b1111;
                wdata = srcData;
            end
            mipsPkg::OP_SH: begin
                // halfword copied into both halves, enables pick one
                wdata = {2{srcData[15:0]}};
                if (addrLow[1]) begin
                    wen = 4'b1100;
                end else begin
                    wen = 4'b0011;
                end
            end
            mipsPkg::OP_SB: begin
                wdata = {4{srcData[7:0]}};
                wen   = 4'b0001 << addrLow;
            end
            default: begin
                // loads and other ops never write
                wen = '0;
            end
        endcase
    end

endmodule

// ==== src/loadAlign.sv ====
`timescale 1ns/1ps

module loadAlign (
    input  mipsPkg::memOp_t op,
    input  logic [1:0]      addrLow,
    input  mipsPkg::word_t  ramWord,
    output mipsPkg::word_t  readData
);

    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // addressed byte lane
    always_comb begin
        case (addrLow)
            2'd0: byteSel = ramWord[7:0];
            2'd1: byteSel = ramWord[15:8];
            2'd2: byteSel = ramWord[23:16];
            default: byteSel = ramWord[31:24];
        endcase
    end

    // halfword lane picked by address bit 1
    assign halfSel = addrLow[1] ? ramWord[31:16] : ramWord[15:0];

    always_comb begin
        case (op)
            mipsPkg::OP_LW: begin
                readData = ramWord;
            end
            mipsPkg::OP_LH: begin
                readData = {{16{halfSel[15]}}, halfSel};
            end
            mipsPkg::OP_LHU: begin
                readData = {16'h0000, halfSel};
            end
            mipsPkg::OP_LB: begin
                readData = {{24{byteSel[7]}}, byteSel};
            end
            mipsPkg::OP_LBU: begin
                readData = {24'h000000, byteSel};
            end
            default: begin
                readData = '0;
            end
        endcase
    end

endmodule

// ==== src/memExcept.sv ====
`timescale 1ns/1ps

module memExcept (
    input  mipsPkg::execData_t execData,
    input  logic [5:0]         extInt,
    input  mipsPkg::intVec_t   causeIp,
    input  mipsPkg::intVec_t   statusIm,
    output mipsPkg::excInfo_t  excInfo
);

    mipsPkg::memOp_t op;
    logic [1:0]      addrLow;
    logic            wordMis;
    logic            halfMis;

    assign op      = execData.op;
    assign addrLow = execData.aluOut[1:0];

    // word needs both low bits clear, halfword only bit 0
    assign wordMis = (addrLow != 2'b00);
    assign halfMis = addrLow[0];

    always_comb begin
        excInfo = '0;

        excInfo.addrLoad  = ((op == mipsPkg::OP_LW) && wordMis) ||
                            ((op == mipsPkg::OP_LH || op == mipsPkg::OP_LHU) && halfMis);
        excInfo.addrStore = ((op == mipsPkg::OP_SW) && wordMis) ||
                            ((op == mipsPkg::OP_SH) && halfMis);

        excInfo.sys  = (op == mipsPkg::OP_SYSCALL);
        excInfo.bp   = (op == mipsPkg::OP_BREAK);
        excInfo.eret = (op == mipsPkg::OP_ERET);

        // external lines land on IP7..IP2, software bits come from cause
        excInfo.pendingInt = ({extInt, 2'b00} | causeIp) & statusIm;

        // pc of the instruction itself, not the one after it
        excInfo.excPc    = execData.pcPlus4 - 32'd4;
        excInfo.badVaddr = execData.aluOut;
    end

endmodule

// ==== src/dataRam.sv ====
`timescale 1ns/1ps

module dataRam #(
    parameter int ramAddrBits = 8
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              ramReq,
    output logic              ramAck,
    input  mipsPkg::ramReq_t  ramCmd,
    output mipsPkg::word_t    ramRdata
);

    localparam int depth = 2 ** ramAddrBits;

    mipsPkg::word_t         mem [depth];
    logic [ramAddrBits-1:0] wordAddr;
    logic                   newReq;

    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // byte offset dropped, upper address bits wrap
    assign wordAddr = ramCmd.addr[ramAddrBits+1:2];

    // request seen while still idle on the ack side
    assign newReq = ramReq && !ramAck;

    // storage and read port
    always_ff @(posedge clk) begin
        if (newReq) begin
            // read returns the word as it was before this write
            ramRdata <= mem[wordAddr];
            for (int lane = 0; lane < 4; lane++) begin
                if (ramCmd.wen[lane]) begin
                    mem[wordAddr][8*lane +: 8] <= ramCmd.wdata[8*lane +: 8];
                end
            end
        end
    end

    // four-phase ack side
    always_ff @(posedge clk) begin
        if (!rstN) begin
            ramAck <= 1'b0;
        end else if (newReq) begin
            ramAck <= 1'b1;
        end else if (!ramReq) begin
            ramAck <= 1'b0;
        end
    end

endmodule

// ==== src/memStage.sv ====
`timescale 1ns/1ps

module memStage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                execReq,
    output logic                execAck,
    input  mipsPkg::execData_t  execData,
    output logic                ramReq,
    input  logic                ramAck,
    output mipsPkg::ramReq_t    ramCmd,
    input  mipsPkg::word_t      ramRdata,
    output logic                wbValid,
    output mipsPkg::memData_t   memData,
    output mipsPkg::excInfo_t   excInfo,
    input  logic [5:0]          extInt,
    input  mipsPkg::intVec_t    causeIp,
    input  mipsPkg::intVec_t    statusIm
);

    typedef enum logic [2:0] {
        stIdle,
        stAccess,
        stRelease,
        stDone,
        stWaitDrop
    } state_t;

    state_t              state;
    mipsPkg::execData_t  exReg;
    mipsPkg::word_t      rdataReg;
    mipsPkg::word_t      loadOut;
    mipsPkg::byteEn_t    storeWen;
    mipsPkg::word_t      storeData;
    mipsPkg::excInfo_t   excNow;
    logic                needRam;
    logic                finish;

    storeAlign storeAlign_i (
        .op      (exReg.op),
        .addrLow (exReg.aluOut[1:0]),
        .srcData (exReg.writeData),
        .wen     (storeWen),
        .wdata   (storeData)
    );

    loadAlign loadAlign_i (
        .op       (exReg.op),
        .addrLow  (exReg.aluOut[1:0]),
        .ramWord  (rdataReg),
        .readData (loadOut)
    );

    memExcept memExcept_i (
        .execData (exReg),
        .extInt   (extInt),
        .causeIp  (causeIp),
        .statusIm (statusIm),
        .excInfo  (excNow)
    );

    // faulting loads and stores stay away from the RAM
    assign needRam = (mipsPkg::isLoad(exReg.op) || mipsPkg::isStore(exReg.op)) &&
                     !excNow.addrLoad && !excNow.addrStore;

    // command held stable for the whole RAM handshake
    assign ramCmd.addr  = exReg.aluOut;
    assign ramCmd.wen   = storeWen;
    assign ramCmd.wdata = storeData;

    // record goes out on this edge
    assign finish = ((state == stAccess) && !needRam) || ((state == stDone) && !ramAck);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state   <= stIdle;
            execAck <= 1'b0;
            wbValid <= 1'b0;
            ramReq  <= 1'b0;
        end else begin
            wbValid <= finish;
            if (finish) begin
                execAck <= 1'b1;
                state   <= stWaitDrop;
            end else begin
                case (state)
                    stIdle: begin
                        if (execReq) begin
                            state <= stAccess;
                        end
                    end
                    stAccess: begin
                        ramReq <= 1'b1;
                        state  <= stRelease;
                    end
                    stRelease: begin
                        if (ramAck) begin
                            ramReq <= 1'b0;
                            state  <= stDone;
                        end
                    end
                    stWaitDrop: begin
                        if (!execReq) begin
                            execAck <= 1'b0;
                            state   <= stIdle;
                        end
                    end
                    default: begin
                        // stDone waits here for ack to fall
                        state <= state;
                    end
                endcase
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if ((state == stIdle) && execReq) begin
            exReg <= execData;
        end
        if ((state == stRelease) && ramAck) begin
            rdataReg <= ramRdata;
        end
        if (finish) begin
            memData.op       <= exReg.op;
            memData.aluOut   <= exReg.aluOut;
            memData.writeReg <= exReg.writeReg;
            memData.pcPlus4  <= exReg.pcPlus4;
            // only a completed RAM read carries load data
            memData.readData <= (state == stDone) ? loadOut : '0;
            excInfo          <= excNow;
        end
    end

endmodule

// ==== src/memTop.sv ====
`timescale 1ns/1ps

module memTop #(
    parameter int ramAddrBits = 8
) (
    input  logic                clk,
    input  logic                rstN,
    input  logic                execReq,
    output logic                execAck,
    input  mipsPkg::execData_t  execData,
    input  logic [5:0]          extInt,
    input  mipsPkg::intVec_t    causeIp,
    input  mipsPkg::intVec_t    statusIm,
    output logic                wbValid,
    output mipsPkg::memData_t   memData,
    output mipsPkg::excInfo_t   excInfo
);

    // stage to RAM handshake
    logic              ramReq;
    logic              ramAck;
    mipsPkg::ramReq_t  ramCmd;
    mipsPkg::word_t    ramRdata;

    memStage memStage_i (
        .clk      (clk),
        .rstN     (rstN),
        .execReq  (execReq),
        .execAck  (execAck),
        .execData (execData),
        .ramReq   (ramReq),
        .ramAck   (ramAck),
        .ramCmd   (ramCmd),
        .ramRdata (ramRdata),
        .wbValid  (wbValid),
        .memData  (memData),
        .excInfo  (excInfo),
        .extInt   (extInt),
        .causeIp  (causeIp),
        .statusIm (statusIm)
    );

    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) dataRam_i (
        .clk      (clk),
        .rstN     (rstN),
        .ramReq   (ramReq),
        .ramAck   (ramAck),
        .ramCmd   (ramCmd),
        .ramRdata (ramRdata)
    );

endmodule

// ==== dv/memTopTb.sv ====
`timescale 1ns/1ps

module memTopTb;

    logic                clk;
    logic                rstN;
    logic                execReq;
    logic                execAck;
    mipsPkg::execData_t  execData;
    logic [5:0]          extInt;
    mipsPkg::intVec_t    causeIp;
    mipsPkg::intVec_t    statusIm;
    logic                wbValid;
    mipsPkg::memData_t   memData;
    mipsPkg::excInfo_t   excInfo;

    integer              seed;
    int                  errValue;
    int                  errProto;
    int                  cycles;
    int                  issued;
    mipsPkg::word_t      shadow [256];
    mipsPkg::memData_t   expMd [$];
    mipsPkg::excInfo_t   expXi [$];

    memTop #(
        .ramAddrBits (8)
    ) memTop_i (
        .clk      (clk),
        .rstN     (rstN),
        .execReq  (execReq),
        .execAck  (execAck),
        .execData (execData),
        .extInt   (extInt),
        .causeIp  (causeIp),
        .statusIm (statusIm),
        .wbValid  (wbValid),
        .memData  (memData),
        .excInfo  (excInfo)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic mipsPkg::word_t randWord();
        return $random(seed);
    endfunction

    // expected record for one request
    // shadow memory takes every store that does not fault
    function automatic void predict(input mipsPkg::execData_t ed, input logic [5:0] ei,
            input mipsPkg::intVec_t ci, input mipsPkg::intVec_t si,
            output mipsPkg::memData_t md, output mipsPkg::excInfo_t xi);
        logic [7:0]     idx;
        logic [1:0]     off;
        mipsPkg::word_t cur;
        logic [7:0]     b;
        logic [15:0]    h;
        idx = ed.aluOut[9:2];
        off = ed.aluOut[1:0];
        cur = shadow[idx];
        b = 8'(cur >> (8 * off));
        h = 16'(cur >> (16 * off[1]));
        xi = '0;
        xi.addrLoad = (ed.op == mipsPkg::OP_LW && off != 2'b00) ||
                      ((ed.op == mipsPkg::OP_LH || ed.op == mipsPkg::OP_LHU) && off[0]);
        xi.addrStore = (ed.op == mipsPkg::OP_SW && off != 2'b00) ||
                       (ed.op == mipsPkg::OP_SH && off[0]);
        xi.sys = (ed.op == mipsPkg::OP_SYSCALL);
        xi.bp = (ed.op == mipsPkg::OP_BREAK);
        xi.eret = (ed.op == mipsPkg::OP_ERET);
        xi.pendingInt = ({ei, 2'b00} | ci) & si;
        xi.excPc = ed.pcPlus4 - 32'd4;
        xi.badVaddr = ed.aluOut;
        md.op = ed.op;
        md.aluOut = ed.aluOut;
        md.writeReg = ed.writeReg;
        md.pcPlus4 = ed.pcPlus4;
        md.readData = '0;
        if (!xi.addrLoad && !xi.addrStore) begin
            case (ed.op)
                mipsPkg::OP_LW:  md.readData = cur;
                mipsPkg::OP_LH:  md.readData = {{16{h[15]}}, h};
                mipsPkg::OP_LHU: md.readData = {16'h0000, h};
                mipsPkg::OP_LB:  md.readData = {{24{b[7]}}, b};
                mipsPkg::OP_LBU: md.readData = {24'h000000, b};
                mipsPkg::OP_SW:  cur = ed.writeData;
                mipsPkg::OP_SH:  cur[16*off[1] +: 16] = ed.writeData[15:0];
                mipsPkg::OP_SB:  cur[8*off +: 8] = ed.writeData[7:0];
                default:         cur = cur;
            endcase
            shadow[idx] = cur;
        end
    endfunction

    task automatic reportMismatch(input string name, input mipsPkg::word_t got,
            input mipsPkg::word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got=%08h exp=%08h", name, got, exp);
            errValue++;
        end
    endtask

    task automatic checkMemData(input mipsPkg::memData_t got, input mipsPkg::memData_t exp);
        reportMismatch("memData.op", 32'(got.op), 32'(exp.op));
        reportMismatch("memData.aluOut", got.aluOut, exp.aluOut);
        reportMismatch("memData.readData", got.readData, exp.readData);
        reportMismatch("memData.writeReg", 32'(got.writeReg), 32'(exp.writeReg));
        reportMismatch("memData.pcPlus4", got.pcPlus4, exp.pcPlus4);
    endtask

    task automatic checkExcInfo(input mipsPkg::excInfo_t got, input mipsPkg::excInfo_t exp);
        reportMismatch("excInfo.addrLoad", 32'(got.addrLoad), 32'(exp.addrLoad));
        reportMismatch("excInfo.addrStore", 32'(got.addrStore), 32'(exp.addrStore));
        reportMismatch("excInfo.sys", 32'(got.sys), 32'(exp.sys));
        reportMismatch("excInfo.bp", 32'(got.bp), 32'(exp.bp));
        reportMismatch("excInfo.eret", 32'(got.eret), 32'(exp.eret));
        reportMismatch("excInfo.pendingInt", 32'(got.pendingInt), 32'(exp.pendingInt));
        reportMismatch("excInfo.excPc", got.excPc, exp.excPc);
        reportMismatch("excInfo.badVaddr", got.badVaddr, exp.badVaddr);
    endtask

    // one full four-phase exchange
    // interrupt inputs stay put for the whole exchange
    task automatic send(input mipsPkg::memOp_t op, input mipsPkg::word_t addr,
            input mipsPkg::word_t data);
        mipsPkg::execData_t ed;
        mipsPkg::memData_t  md;
        mipsPkg::excInfo_t  xi;
        logic [5:0]         ei;
        mipsPkg::intVec_t   ci;
        mipsPkg::intVec_t   si;
        mipsPkg::word_t     w;
        w = randWord();
        ed.op = op;
        ed.aluOut = addr;
        ed.writeData = data;
        ed.writeReg = w[4:0];
        ed.pcPlus4 = {w[31:2], 2'b00};
        w = randWord();
        ei = w[5:0];
        ci = w[15:8];
        si = w[23:16];
        predict(ed, ei, ci, si, md, xi);
        expMd.push_back(md);
        expXi.push_back(xi);
        issued++;
        @(posedge clk);
        execData <= ed;
        extInt <= ei;
        causeIp <= ci;
        statusIm <= si;
        execReq <= 1'b1;
        do @(posedge clk); while (!execAck);
        execReq <= 1'b0;
        do @(posedge clk); while (execAck);
    endtask

    // aligned base in the low part of the RAM so later loads hit earlier stores
    function automatic mipsPkg::word_t randBase();
        mipsPkg::word_t w;
        w = randWord();
        return {w[31:10], 4'b0000, w[5:2], 2'b00};
    endfunction

    task automatic runWordRoundTrip();
        mipsPkg::word_t a;
        for (int i = 0; i < 16; i++) begin
            a = randBase();
            send(mipsPkg::OP_SW, a, randWord());
            send(mipsPkg::OP_LW, a, randWord());
        end
    endtask

    task automatic runSubWord();
        mipsPkg::word_t a;
        for (int i = 0; i < 4; i++) begin
            a = randBase();
            send(mipsPkg::OP_SW, a, randWord());
            // halfword lands in the half away from the byte lane
            send(mipsPkg::OP_SH, a + 32'(i < 2 ? 2 : 0), randWord());
            send(mipsPkg::OP_SB, a + 32'(i), randWord());
            for (int off = 0; off < 4; off++) begin
                send(mipsPkg::OP_LB, a + 32'(off), randWord());
                send(mipsPkg::OP_LBU, a + 32'(off), randWord());
            end
            for (int off = 0; off < 4; off += 2) begin
                send(mipsPkg::OP_LH, a + 32'(off), randWord());
                send(mipsPkg::OP_LHU, a + 32'(off), randWord());
            end
            send(mipsPkg::OP_LW, a, randWord());
        end
    endtask

    task automatic runMisaligned();
        mipsPkg::word_t a;
        a = randBase();
        send(mipsPkg::OP_SW, a, randWord());
        for (int off = 1; off < 4; off++) begin
            send(mipsPkg::OP_LW, a + 32'(off), randWord());
            send(mipsPkg::OP_SW, a + 32'(off), randWord());
        end
        for (int off = 1; off < 4; off += 2) begin
            send(mipsPkg::OP_LH, a + 32'(off), randWord());
            send(mipsPkg::OP_LHU, a + 32'(off), randWord());
            send(mipsPkg::OP_SH, a + 32'(off), randWord());
        end
        // word must still hold the first store
        send(mipsPkg::OP_LW, a, randWord());
    endtask

    task automatic runOpFlags();
        mipsPkg::word_t a;
        a = randBase();
        send(mipsPkg::OP_SYSCALL, a, randWord());
        send(mipsPkg::OP_BREAK, a, randWord());
        send(mipsPkg::OP_ERET, a, randWord());
        send(mipsPkg::OP_NONE, a, randWord());
        send(mipsPkg::OP_LW, a, randWord());
    endtask

    task automatic runRandomMix();
        logic [3:0]     k;
        mipsPkg::word_t w;
        for (int i = 0; i < 60; i++) begin
            k = 4'($unsigned($random(seed)) % 12);
            w = randWord();
            send(mipsPkg::memOp_t'(k), {w[31:10], 4'b0000, w[5:0]}, randWord());
        end
    endtask

    // compare every writeback record against the queued prediction
    always @(posedge clk) begin
        if (rstN && wbValid) begin
            if (expMd.size() == 0) begin
                $display("writeback record arrived with no request outstanding");
                errProto++;
            end else begin
                checkMemData(memData, expMd.pop_front());
                checkExcInfo(excInfo, expXi.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 20 * issued + 100) begin
            $display("timeout after %0d cycles with %0d requests issued", cycles, issued);
            $display("errors: value=%0d protocol=%0d", errValue, errProto + 1);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed = 32'hcb268f28;
        errValue = 0;
        errProto = 0;
        cycles = 0;
        issued = 0;
        rstN = 1'b0;
        execReq = 1'b0;
        execData = '0;
        extInt = '0;
        causeIp = '0;
        statusIm = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) begin
            @(posedge clk);
            if (execAck !== 1'b0 || wbValid !== 1'b0) begin
                $display("execAck or wbValid not low after reset");
                errProto++;
            end
        end
        runWordRoundTrip();
        runSubWord();
        runMisaligned();
        runOpFlags();
        runRandomMix();
        repeat (4) @(posedge clk);
        if (expMd.size() != 0) begin
            $display("%0d writeback records never arrived", expMd.size());
            errProto++;
        end
        $display("errors: value=%0d protocol=%0d", errValue, errProto);
        if (errValue == 0 && errProto == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/mipsPkg.sv
src/storeAlign.sv
src/loadAlign.sv
src/memExcept.sv
src/dataRam.sv
src/memStage.sv
src/memTop.sv
dv/memTopTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f sources.f \
    --top-module memTopTb \
    -o memTopSim

./obj_dir/memTopSim | tee sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
